// ==== logic/snd_consts.svh ====
// sound block constants
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

`define SND_VOICES      2       // pcm voices
`define SND_ADDR_W      19      // rom byte address
`define SND_APB_AW      8
`define SND_DIV_W       16      // sample rate divider

// global registers
`define SND_REG_CTRL    8'h00   // bit 0 enable
`define SND_REG_RATE    8'h04
`define SND_REG_STATUS  8'h08   // read only, active bit per voice

// voice registers, base + 0x10 per voice
`define SND_VREG_BASE   8'h10
`define SND_VREG_START  4'h0
`define SND_VREG_END    4'h4
`define SND_VREG_GAIN   4'h8
`define SND_VREG_CTRL   4'hC

// voice ctrl bits
`define SND_VCTRL_KEYON 0       // write only, self clearing
`define SND_VCTRL_LOOP  1
`define SND_VCTRL_PANL  2
`define SND_VCTRL_PANR  3

`endif

// ==== logic/snd_pkg.sv ====
// sound block types
`include "snd_consts.svh"

package snd_pkg;

    // byte address into the sample rom
    typedef logic [`SND_ADDR_W-1:0] pcm_addr_t;

    // raw pcm sample, two's complement
    typedef logic signed [7:0] pcm_sample_t;

    // 4.4 fixed point, 0x10 is unity
    typedef logic [7:0] snd_gain_t;

    // fetch sequencer
    typedef enum logic [2:0] {
        IDLE,   // waiting for a tick
        REQ,    // look at the current voice
        WAIT,   // rom transfer in flight
        NEXT,   // step past a fetched voice
        MIX     // pass done, strobe the mixer
    } fetch_state_t;

endpackage

// ==== logic/snd_regs.sv ====
// apb register file
`include "snd_consts.svh"

module snd_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    // apb
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`SND_APB_AW-1:0]   paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    // global settings
    output logic                     enable,
    output logic [`SND_DIV_W-1:0]    rate_div,
    // voice settings
    output snd_pkg::pcm_addr_t       start_addr [`SND_VOICES],
    output snd_pkg::pcm_addr_t       end_addr   [`SND_VOICES],
    output snd_pkg::snd_gain_t       gain       [`SND_VOICES],
    output logic [`SND_VOICES-1:0]   loop,
    output logic [`SND_VOICES-1:0]   pan_left,
    output logic [`SND_VOICES-1:0]   pan_right,
    output logic [`SND_VOICES-1:0]   key_on,
    input  logic [`SND_VOICES-1:0]   active
);

    localparam int VW = $clog2(`SND_VOICES);

    logic                   access;
    logic                   mapped;
    logic                   ro_hit;
    logic                   wr_en;
    logic                   voice_hit;
    logic [`SND_APB_AW-1:0] voff;
    logic [`SND_APB_AW-5:0] vidx;
    logic [VW-1:0]          vsel;
    logic [3:0]             vreg;

    assign access = psel & penable;        // apb access phase
    assign voff   = paddr - `SND_VREG_BASE;
    assign vidx   = voff[`SND_APB_AW-1:4];
    assign vsel   = vidx[VW-1:0];
    assign vreg   = voff[3:0];

    assign voice_hit = (paddr >= `SND_VREG_BASE) && (vidx < `SND_VOICES);
    assign ro_hit    = paddr == `SND_REG_STATUS;

    // decode and read mux
    always_comb begin
        mapped = 1'b0;
        prdata = '0;
        if (paddr == `SND_REG_CTRL) begin
            mapped = 1'b1;
            prdata = 32'(enable);
        end else if (paddr == `SND_REG_RATE) begin
            mapped = 1'b1;
            prdata = 32'(rate_div);
        end else if (ro_hit) begin
            mapped = 1'b1;
            prdata = 32'(active);          // live voice status
        end else if (voice_hit) begin
            case (vreg)
                `SND_VREG_START: begin
                    mapped = 1'b1;
                    prdata = 32'(start_addr[vsel]);
                end
                `SND_VREG_END: begin
                    mapped = 1'b1;
                    prdata = 32'(end_addr[vsel]);
                end
                `SND_VREG_GAIN: begin
                    mapped = 1'b1;
                    prdata = 32'(gain[vsel]);
                end
                `SND_VREG_CTRL: begin
                    mapped = 1'b1;
                    // key-on never reads back
                    prdata = 32'({pan_right[vsel], pan_left[vsel], loop[vsel], 1'b0});
                end
                default: mapped = 1'b0;
            endcase
        end
    end

    assign pready  = 1'b1;                  // zero wait states
    assign pslverr = access & (~mapped | (pwrite & ro_hit));
    assign wr_en   = access & pwrite & mapped & ~ro_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable    <= 1'b0;
            rate_div  <= '0;
            loop      <= '0;
            pan_left  <= '0;
            pan_right <= '0;
            key_on    <= '0;
            for (int v = 0; v < `SND_VOICES; v++) begin
                start_addr[v] <= '0;
                end_addr[v]   <= '0;
                gain[v]       <= '0;
            end
        end else begin
            key_on <= '0;                   // one cycle pulse
            if (wr_en) begin
                if (paddr == `SND_REG_CTRL) begin
                    enable <= pwdata[0];
                end else if (paddr == `SND_REG_RATE) begin
                    rate_div <= pwdata[`SND_DIV_W-1:0];
                end else begin
                    case (vreg)
                        `SND_VREG_START: start_addr[vsel] <= pwdata[`SND_ADDR_W-1:0];
                        `SND_VREG_END:   end_addr[vsel]   <= pwdata[`SND_ADDR_W-1:0];
                        `SND_VREG_GAIN:  gain[vsel]       <= pwdata[7:0];
                        default: begin
                            key_on[vsel]    <= pwdata[`SND_VCTRL_KEYON];
                            loop[vsel]      <= pwdata[`SND_VCTRL_LOOP];
                            pan_left[vsel]  <= pwdata[`SND_VCTRL_PANL];
                            pan_right[vsel] <= pwdata[`SND_VCTRL_PANR];
                        end
                    endcase
                end
            end
        end
    end

endmodule

// ==== logic/snd_tick_timer.sv ====
// sample rate timer
`include "snd_consts.svh"

module snd_tick_timer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [`SND_DIV_W-1:0] rate_div,
    output logic                  tick
);

    logic [`SND_DIV_W-1:0] count;

    // one tick every rate_div+1 clocks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (!enable) begin
                count <= rate_div;          // parked at reload
            end else if (count == '0) begin
                count <= rate_div;
                tick  <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/pcm_fetch_fsm.sv ====
// pcm voice fetch sequencer
`include "snd_consts.svh"

module pcm_fetch_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    tick,
    input  logic [`SND_VOICES-1:0]  key_on,
    input  snd_pkg::pcm_addr_t      start_addr [`SND_VOICES],
    input  snd_pkg::pcm_addr_t      end_addr   [`SND_VOICES],
    input  logic [`SND_VOICES-1:0]  loop,
    // sample rom
    output snd_pkg::pcm_addr_t      rom_addr,
    output logic                    rom_cs,
    input  logic [7:0]              rom_data,
    input  logic                    rom_ok,
    // to mixer and status
    output snd_pkg::pcm_sample_t    samples [`SND_VOICES],
    output logic [`SND_VOICES-1:0]  active,
    output logic                    mix_strobe
);

    import snd_pkg::*;

    localparam int VW = $clog2(`SND_VOICES);

    fetch_state_t   state;
    logic [VW-1:0]  vcur;                   // voice being served
    logic           last;
    pcm_addr_t      addr [`SND_VOICES];     // next byte per voice

    assign last = vcur == VW'(`SND_VOICES - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            vcur       <= '0;
            rom_cs     <= 1'b0;
            rom_addr   <= '0;
            mix_strobe <= 1'b0;
            active     <= '0;
            for (int v = 0; v < `SND_VOICES; v++) begin
                addr[v]    <= '0;
                samples[v] <= '0;
            end
        end else begin
            mix_strobe <= 1'b0;
            case (state)
                IDLE: begin
                    if (tick) begin         // busy ticks are simply lost
                        vcur  <= '0;
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (active[vcur]) begin
                        rom_cs   <= 1'b1;
                        rom_addr <= addr[vcur];
                        state    <= WAIT;
                    end else begin
                        samples[vcur] <= '0;    // silent voice, one cycle
                        if (last) begin
                            state <= MIX;
                        end else begin
                            vcur <= vcur + 1'b1;
                        end
                    end
                end
                WAIT: begin
                    if (rom_ok) begin
                        rom_cs        <= 1'b0;
                        samples[vcur] <= pcm_sample_t'(rom_data);
                        // end and loop rule on the byte just read
                        if (rom_addr == end_addr[vcur]) begin
                            if (loop[vcur]) begin
                                addr[vcur] <= start_addr[vcur];
                            end else begin
                                active[vcur] <= 1'b0;
                            end
                        end else begin
                            addr[vcur] <= rom_addr + 1'b1;
                        end
                        state <= NEXT;
                    end
                end
                NEXT: begin
                    if (last) begin
                        state <= MIX;
                    end else begin
                        vcur  <= vcur + 1'b1;
                        state <= REQ;
                    end
                end
                MIX: begin
                    mix_strobe <= 1'b1;
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase

            // key-on wins over the fetch update
            for (int v = 0; v < `SND_VOICES; v++) begin
                if (key_on[v]) begin
                    addr[v]   <= start_addr[v];
                    active[v] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/snd_mixer.sv ====
// pcm gain and pan mixer
`include "snd_consts.svh"

module snd_mixer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    mix_strobe,
    input  snd_pkg::pcm_sample_t    samples [`SND_VOICES],
    input  snd_pkg::snd_gain_t      gain    [`SND_VOICES],
    input  logic [`SND_VOICES-1:0]  pan_left,
    input  logic [`SND_VOICES-1:0]  pan_right,
    output logic signed [15:0]      snd_left,
    output logic signed [15:0]      snd_right,
    output logic                    sample,
    output logic                    peak
);

    // 8b sample, x256, 9b signed gain, plus growth for the sum
    localparam int CW = 25 + $clog2(`SND_VOICES);

    logic signed [CW-1:0] contrib [`SND_VOICES];
    logic signed [CW-1:0] sum_l;
    logic signed [CW-1:0] sum_r;
    logic signed [15:0]   sat_l;
    logic signed [15:0]   sat_r;
    logic                 ovf_l;
    logic                 ovf_r;

    function automatic logic signed [15:0] sat16(input logic signed [CW-1:0] x);
        if (x > 32767) begin
            return 16'sh7fff;
        end else if (x < -32768) begin
            return 16'sh8000;
        end
        return x[15:0];
    endfunction

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int v = 0; v < `SND_VOICES; v++) begin
            // gain is 4.4, so drop four fraction bits
            contrib[v] = ((CW'(samples[v]) <<< 8) * $signed({1'b0, gain[v]})) >>> 4;
            if (pan_left[v])  sum_l = sum_l + contrib[v];
            if (pan_right[v]) sum_r = sum_r + contrib[v];
        end
        sat_l = sat16(sum_l);
        sat_r = sat16(sum_r);
        ovf_l = sum_l != CW'(sat_l);        // clipped
        ovf_r = sum_r != CW'(sat_r);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_left  <= '0;
            snd_right <= '0;
            peak      <= 1'b0;
            sample    <= 1'b0;
        end else begin
            sample <= mix_strobe;           // marks the new output
            if (mix_strobe) begin
                snd_left  <= sat_l;
                snd_right <= sat_r;
                peak      <= ovf_l | ovf_r;
            end
        end
    end

endmodule

// ==== logic/snd_top.sv ====
// pcm sound block
`include "snd_consts.svh"

module snd_top (
    input  logic                    clk,
    input  logic                    arst_n,
    // apb host port
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`SND_APB_AW-1:0]  paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    // sample rom
    output snd_pkg::pcm_addr_t      rom_addr,
    output logic                    rom_cs,
    input  logic [7:0]              rom_data,
    input  logic                    rom_ok,
    // sound output
    output logic signed [15:0]      snd_left,
    output logic signed [15:0]      snd_right,
    output logic                    sample,
    output logic                    peak
);

    logic                   enable;
    logic [`SND_DIV_W-1:0]  rate_div;
    logic                   tick;
    logic                   mix_strobe;
    logic [`SND_VOICES-1:0] loop;
    logic [`SND_VOICES-1:0] pan_left;
    logic [`SND_VOICES-1:0] pan_right;
    logic [`SND_VOICES-1:0] key_on;
    logic [`SND_VOICES-1:0] active;
    snd_pkg::pcm_addr_t     start_addr [`SND_VOICES];
    snd_pkg::pcm_addr_t     end_addr   [`SND_VOICES];
    snd_pkg::snd_gain_t     gain       [`SND_VOICES];
    snd_pkg::pcm_sample_t   samples    [`SND_VOICES];

    snd_regs u_regs (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .psel       ( psel       ),
        .penable    ( penable    ),
        .pwrite     ( pwrite     ),
        .paddr      ( paddr      ),
        .pwdata     ( pwdata     ),
        .prdata     ( prdata     ),
        .pready     ( pready     ),
        .pslverr    ( pslverr    ),
        .enable     ( enable     ),
        .rate_div   ( rate_div   ),
        .start_addr ( start_addr ),
        .end_addr   ( end_addr   ),
        .gain       ( gain       ),
        .loop       ( loop       ),
        .pan_left   ( pan_left   ),
        .pan_right  ( pan_right  ),
        .key_on     ( key_on     ),
        .active     ( active     )
    );

    snd_tick_timer u_timer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .enable     ( enable     ),
        .rate_div   ( rate_div   ),
        .tick       ( tick       )
    );

    pcm_fetch_fsm u_fetch (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .tick       ( tick       ),
        .key_on     ( key_on     ),
        .start_addr ( start_addr ),
        .end_addr   ( end_addr   ),
        .loop       ( loop       ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .samples    ( samples    ),
        .active     ( active     ),
        .mix_strobe ( mix_strobe )
    );

    snd_mixer u_mixer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .mix_strobe ( mix_strobe ),
        .samples    ( samples    ),
        .gain       ( gain       ),
        .pan_left   ( pan_left   ),
        .pan_right  ( pan_right  ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

endmodule

// ==== testbench/snd_tb.sv ====
// sound block testbench
`include "snd_consts.svh"

module snd_tb;

    localparam int RATE    = 39;        // a full pass takes at most about 16 clocks
    localparam int SAMPLES = 43;        // sample pulses checked over all tests
    localparam int TIMEOUT = SAMPLES * (RATE + 1) + 1500;   // apb traffic, idle window, rom waits

    logic                   clk;
    logic                   arst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`SND_APB_AW-1:0] paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic [`SND_ADDR_W-1:0] rom_addr;
    logic                   rom_cs;
    logic [7:0]             rom_data;
    logic                   rom_ok;
    logic signed [15:0]     snd_left;
    logic signed [15:0]     snd_right;
    logic                   sample;
    logic                   peak;

    logic [7:0]  rom_mem [512];
    logic [31:0] lcg_state;
    int          cycles = 0;
    bit          rom_busy;
    int          rom_wait;
    int          peak_count;

    // register mirror and voice model
    logic        m_en;
    logic [15:0] m_rate;
    int          m_start  [`SND_VOICES];
    int          m_end    [`SND_VOICES];
    int          m_gain   [`SND_VOICES];
    int          m_addr   [`SND_VOICES];
    logic [3:0]  m_ctrl   [`SND_VOICES];  // loop and pan, bit 0 always clear
    bit          m_active [`SND_VOICES];

    snd_top u_snd_top (.*);

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) report_failure("timeout: the tests did not finish in time");
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rom answers after 0 to 3 cycles
    always @(negedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cs && rom_addr >= 512) begin
            report_failure("rom request above the 512 byte sample memory");
        end else if (rom_cs) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_wait = int'(next_random() >> 30);
            end
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_mem[rom_addr[8:0]];
                rom_busy = 1'b0;
            end else begin
                rom_wait--;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            report_failure($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;             // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #2;
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value($sformatf("pslverr write 0x%0h", addr), 32'(err), 32'h0);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rd, err);
        check_value($sformatf("pslverr read 0x%0h", addr), 32'(err), 32'h0);
        check_value(name, rd, exp);
    endtask

    function automatic logic [7:0] voice_addr(input int v, input int off);
        return 8'(`SND_VREG_BASE + 16 * v + off);
    endfunction

    function automatic logic [31:0] status_bits();
        logic [31:0] s;
        s = '0;
        for (int v = 0; v < `SND_VOICES; v++) s[v] = m_active[v];
        return s;
    endfunction

    task automatic set_enable(input logic en);
        write_reg(`SND_REG_CTRL, 32'(en));
        m_en = en;
    endtask

    task automatic set_ctrl(input int v, input logic [3:0] ctrl);
        write_reg(voice_addr(v, `SND_VREG_CTRL), 32'(ctrl));
        m_ctrl[v] = ctrl & 4'hE;
        if (ctrl[`SND_VCTRL_KEYON]) begin   // restart from start
            m_addr[v]   = m_start[v];
            m_active[v] = 1'b1;
        end
    endtask

    task automatic set_voice(input int v, input int start, input int stop, input int g,
                             input logic [3:0] ctrl);
        write_reg(voice_addr(v, `SND_VREG_START), 32'(start));
        write_reg(voice_addr(v, `SND_VREG_END), 32'(stop));
        write_reg(voice_addr(v, `SND_VREG_GAIN), 32'(g));
        m_start[v] = start;
        m_end[v]   = stop;
        m_gain[v]  = g;
        set_ctrl(v, ctrl);
    endtask

    task automatic check_regs();
        read_check("ctrl", `SND_REG_CTRL, 32'(m_en));
        read_check("rate", `SND_REG_RATE, 32'(m_rate));
        read_check("status", `SND_REG_STATUS, status_bits());
        for (int v = 0; v < `SND_VOICES; v++) begin
            read_check($sformatf("start%0d", v), voice_addr(v, `SND_VREG_START), 32'(m_start[v]));
            read_check($sformatf("end%0d", v), voice_addr(v, `SND_VREG_END), 32'(m_end[v]));
            read_check($sformatf("gain%0d", v), voice_addr(v, `SND_VREG_GAIN), 32'(m_gain[v]));
            read_check($sformatf("vctrl%0d", v), voice_addr(v, `SND_VREG_CTRL), 32'(m_ctrl[v]));
        end
    endtask

    function automatic logic [15:0] clamp16(input int x);
        if (x > 32767) return 16'h7fff;
        if (x < -32768) return 16'h8000;
        return 16'(x);
    endfunction

    function automatic bit clipped(input int x);
        return (x > 32767) || (x < -32768);
    endfunction

    // one fetch pass of the reference model
    task automatic model_pass(output logic [15:0] exp_l, output logic [15:0] exp_r,
                              output logic exp_pk);
        int s;
        int sum_l;
        int sum_r;
        sum_l = 0;
        sum_r = 0;
        for (int v = 0; v < `SND_VOICES; v++) begin
            s = 0;                          // silent when inactive
            if (m_active[v]) begin
                s = int'($signed(rom_mem[m_addr[v]]));
                if (m_addr[v] != m_end[v]) m_addr[v]++;
                else if (m_ctrl[v][`SND_VCTRL_LOOP]) m_addr[v] = m_start[v];
                else m_active[v] = 1'b0;
            end
            // sample x256, times 4.4 gain, over 16
            if (m_ctrl[v][`SND_VCTRL_PANL]) sum_l += s * m_gain[v] * 16;
            if (m_ctrl[v][`SND_VCTRL_PANR]) sum_r += s * m_gain[v] * 16;
        end
        exp_l  = clamp16(sum_l);
        exp_r  = clamp16(sum_r);
        exp_pk = clipped(sum_l) || clipped(sum_r);
    endtask

    task automatic wait_sample();
        @(negedge clk);
        while (!sample) @(negedge clk);
    endtask

    task automatic play_and_check(input int n);
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        logic        exp_pk;
        repeat (n) begin
            wait_sample();
            model_pass(exp_l, exp_r, exp_pk);
            check_value("snd_left", {16'h0, snd_left}, {16'h0, exp_l});
            check_value("snd_right", {16'h0, snd_right}, {16'h0, exp_r});
            check_value("peak", 32'(peak), 32'(exp_pk));
            if (peak) peak_count++;
        end
    endtask

    task automatic registers_rw();
        logic [7:0]  bad [5];
        logic [31:0] rd;
        logic        err;
        bad = '{8'h0C, 8'h02, 8'h11, 8'h30, 8'hFC};
        check_regs();                       // reset values
        write_reg(`SND_REG_RATE, 32'h1234);
        m_rate = 16'h1234;
        set_enable(1'b1);
        check_regs();
        set_enable(1'b0);
        for (int v = 0; v < `SND_VOICES; v++) begin
            set_voice(v, 'h100 + 'h10 * v, 'h103 + 'h10 * v, 'h5A + v, 4'hF);
        end
        check_regs();                       // key-on bit reads as zero
        foreach (bad[i]) begin
            apb_xfer(1'b1, bad[i], 32'hFFFF_FFFF, rd, err);
            check_value($sformatf("pslverr write 0x%0h", bad[i]), 32'(err), 32'h1);
            apb_xfer(1'b0, bad[i], 32'h0, rd, err);
            check_value($sformatf("pslverr read 0x%0h", bad[i]), 32'(err), 32'h1);
        end
        apb_xfer(1'b1, `SND_REG_STATUS, 32'hFFFF_FFFF, rd, err);
        check_value("pslverr write status", 32'(err), 32'h1);
        check_regs();
        for (int v = 0; v < `SND_VOICES; v++) set_ctrl(v, 4'h0);
        write_reg(`SND_REG_RATE, 32'(RATE));
        m_rate = 16'(RATE);
    endtask

    task automatic single_voice_play();
        set_voice(0, 'h010, 'h015, 'h10, 4'hD);     // unity gain, both sides
        set_enable(1'b1);
        play_and_check(6);
        read_check("status", `SND_REG_STATUS, 32'h0);
        play_and_check(1);                          // silence after the end byte
        set_enable(1'b0);
    endtask

    task automatic loop_play();
        set_voice(0, 'h020, 'h023, 'h10, 4'hF);
        set_enable(1'b1);
        play_and_check(10);
        set_enable(1'b0);
    endtask

    task automatic two_voice_mix();
        set_voice(0, 'h040, 'h04F, 'h18, 4'h5);     // left only
        set_voice(1, 'h080, 'h087, 'h08, 4'h8);     // right only, keyed later
        set_enable(1'b1);
        play_and_check(4);
        set_ctrl(1, 4'h9);
        play_and_check(8);
        set_enable(1'b0);
    endtask

    task automatic saturation_peak();
        rom_mem['h1F0] = 8'h7F;
        rom_mem['h1F1] = 8'h80;
        rom_mem['h1F2] = 8'h10;
        rom_mem['h1F3] = 8'h00;
        rom_mem['h1F8] = 8'h40;
        rom_mem['h1F9] = 8'hC0;
        peak_count = 0;
        set_voice(0, 'h1F0, 'h1F3, 'h40, 4'hF);
        set_voice(1, 'h1F8, 'h1F9, 'h20, 4'hB);
        set_enable(1'b1);
        play_and_check(8);
        // three of every four passes clip, the fourth lands on -32768 exactly
        check_value("peak count", 32'(peak_count), 32'd6);
    endtask

    task automatic disable_resume();
        int pulses;
        pulses = 0;
        set_enable(1'b0);
        repeat (3 * (RATE + 1)) begin
            @(negedge clk);
            if (sample) pulses++;
        end
        check_value("sample pulses while disabled", 32'(pulses), 32'h0);
        set_enable(1'b1);
        play_and_check(6);
        set_enable(1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        rom_busy  = 1'b0;
        rom_wait  = 0;
        lcg_state = 32'd26;
        m_en      = 1'b0;
        m_rate    = '0;
        for (int v = 0; v < `SND_VOICES; v++) begin
            m_start[v]  = 0;
            m_end[v]    = 0;
            m_gain[v]   = 0;
            m_addr[v]   = 0;
            m_ctrl[v]   = '0;
            m_active[v] = 1'b0;
        end
        for (int i = 0; i < 512; i++) rom_mem[i] = 8'(next_random() >> 16);
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        registers_rw();
        single_voice_play();
        loop_play();
        two_voice_mix();
        saturation_peak();
        disable_resume();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/snd_pkg.sv
logic/snd_regs.sv
logic/snd_tick_timer.sv
logic/pcm_fetch_fsm.sv
logic/snd_mixer.sv
logic/snd_top.sv
testbench/snd_tb.sv

// ==== Makefile ====
TOP := snd_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP)

# verdict comes from the pass line in the simulation output
run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
